// File: hdl/arbPkg.sv
package arbPkg;

  // One-hot, bit 0 is idle and bits 1 to 5 follow the port order
  typedef enum logic [5:0] {
    stIdle  = 6'b000001,
    stLocal = 6'b000010,
    stNorth = 6'b000100,
    stEast  = 6'b001000,
    stWest  = 6'b010000,
    stSouth = 6'b100000
  } arbStateT;

  localparam int fifoDepth = 4;

  typedef logic [$clog2(fifoDepth)-1:0] fifoPtrT;

endpackage

// File: hdl/flitFifo.sv
`timescale 1ns/1ps

module flitFifo (
  input  logic         clk,
  input  logic         rst,
  input  logic         wrEn,
  input  nocPkg::flitT wrFlit,
  output logic         full,
  flitQueueIf.queue    q
);
  import nocPkg::*;
  import arbPkg::*;

  flitT       mem [fifoDepth];
  fifoPtrT    wrPtr;
  fifoPtrT    rdPtr;
  logic [2:0] count;
  logic       doPush;
  logic       doPop;

  assign doPush = wrEn && (count != 3'(fifoDepth));
  assign doPop  = q.pop && (count != 3'd0);

  // ~~~~~~~~~~~~~~~~~~~~
  // Storage
  // ~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge clk)
  begin
    if (doPush)
      mem[wrPtr] <= wrFlit;
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end
    else
    begin
      if (doPush)
        wrPtr <= wrPtr + 1'b1;   // Depth is a power of two, wraps by itself
      if (doPop)
        rdPtr <= rdPtr + 1'b1;
      case ({doPush, doPop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~
  // Status
  // ~~~~~~~~~~~~~~~~~~~~
  assign q.req      = (count != 3'd0);
  assign q.headFlit = mem[rdPtr];

  // The write in flight from the framer already owns a slot
  assign full = (count + 3'(wrEn)) == 3'(fifoDepth);

endmodule

// File: hdl/flitQueueIf.sv
`timescale 1ns/1ps

interface flitQueueIf;
  import nocPkg::*;

  logic   req;       // Queue not empty
  flitT   headFlit;
  lengthT quota;     // Length of the latest accepted header
  logic   pop;       // One cycle strobe, only while req is high

  // Queue side, shared by the FIFO and the input framer
  modport queue (
    output req,
    output headFlit,
    output quota,
    input  pop
  );

  modport arb (
    input  req,
    input  headFlit,
    input  quota,
    output pop
  );

endinterface

// File: hdl/grantTimer.sv
`timescale 1ns/1ps

module grantTimer (
  input  logic           clk,
  input  logic           rst,
  input  nocPkg::lengthT quota,
  input  logic           run,
  output logic           timesup
);
  import nocPkg::*;

  lengthT count;   // Flits sent in the current grant turn

  always_ff @(posedge clk)
  begin
    if (rst)
      count <= '0;
    else if (!run)
      count <= '0;
    else
      count <= count + 1'b1;
  end

  // Also ends the turn when a new header lowers the quota mid grant
  assign timesup = (count >= quota);

endmodule

// File: hdl/nocPkg.sv
package nocPkg;

  // ~~~~~~~~~~~~~~~~~~~~
  // Router geometry
  // ~~~~~~~~~~~~~~~~~~~~
  localparam int numPorts = 5;  // L, N, E, W, S

  typedef logic [2:0] portIdxT;

  // ~~~~~~~~~~~~~~~~~~~~
  // Flit format
  // ~~~~~~~~~~~~~~~~~~~~
  typedef logic [2:0]  flitIdT;
  typedef logic [11:0] lengthT;   // Header length, also the grant quota
  typedef logic [14:0] flitT;     // {id, payload}

  localparam flitIdT idHeader = 3'b001;
  localparam flitIdT idBody   = 3'b010;
  localparam flitIdT idTail   = 3'b100;

endpackage

// File: hdl/outputArbiter.sv
`timescale 1ns/1ps

module outputArbiter (
  input  logic            clk,
  input  logic            rst,
  flitQueueIf.arb         lane [nocPkg::numPorts],
  output logic            outValid,
  output nocPkg::flitT    outFlit,
  output nocPkg::portIdxT outPort
);
  import nocPkg::*;
  import arbPkg::*;

  arbStateT              curState;
  arbStateT              nextState;
  portIdxT               curIdx;
  logic                  isIdle;
  logic [numPorts-1:0]   reqVec;
  logic [numPorts-1:0]   timesupVec;
  logic [numPorts-1:0]   grant;     // Run and pop of the granted port
  flitT                  heads [numPorts];

  // First requesting port after "from", wrapping back to "from" last
  function automatic arbStateT pickNext(portIdxT from, logic [numPorts-1:0] req);
    portIdxT  idx;
    arbStateT pick;
    idx  = from;
    pick = stIdle;
    for (int k = 0; k < numPorts; k++)
    begin
      idx = (idx == portIdxT'(numPorts - 1)) ? portIdxT'(0) : idx + 1'b1;
      if (req[idx] && pick == stIdle)
        pick = arbStateT'(6'b000010 << idx);
    end
    return pick;
  endfunction

  // ~~~~~~~~~~~~~~~~~~~~
  // Per-port lanes
  // ~~~~~~~~~~~~~~~~~~~~
  for (genvar i = 0; i < numPorts; i++)
  begin : gLane
    assign reqVec[i]   = lane[i].req;
    assign heads[i]    = lane[i].headFlit;
    assign lane[i].pop = grant[i];

    grantTimer uTimer (
      .clk     (clk),
      .rst     (rst),
      .quota   (lane[i].quota),
      .run     (grant[i]),
      .timesup (timesupVec[i])
    );
  end

  // ~~~~~~~~~~~~~~~~~~~~
  // Grant FSM
  // ~~~~~~~~~~~~~~~~~~~~
  always_comb
  begin
    curIdx = portIdxT'(numPorts - 1);   // Idle searches from L
    isIdle = 1'b0;
    case (curState)
      stLocal: curIdx = portIdxT'(0);
      stNorth: curIdx = portIdxT'(1);
      stEast:  curIdx = portIdxT'(2);
      stWest:  curIdx = portIdxT'(3);
      stSouth: curIdx = portIdxT'(4);
      stIdle:  isIdle = 1'b1;
      default: isIdle = 1'b1;
    endcase
  end

  always_comb
  begin
    grant = '0;
    if (!isIdle && reqVec[curIdx] && !timesupVec[curIdx])
    begin
      grant[curIdx] = 1'b1;
      nextState     = curState;
    end
    else
      nextState = pickNext(curIdx, reqVec);   // Goes idle when nobody asks
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      curState <= stIdle;
      outValid <= 1'b0;
    end
    else
    begin
      curState <= nextState;
      outValid <= |grant;
    end
  end

  // Output channel
  always_ff @(posedge clk)
  begin
    if (|grant)
    begin
      outFlit <= heads[curIdx];
      outPort <= curIdx;
    end
  end

endmodule

// File: hdl/portInput.sv
`timescale 1ns/1ps

module portInput (
  input  logic         clk,
  input  logic         rst,
  input  logic         inValid,
  input  nocPkg::flitT inFlit,
  input  logic         full,
  output logic         wrEn,
  output nocPkg::flitT wrFlit,
  output logic         dropped,
  flitQueueIf.queue    q
);
  import nocPkg::*;

  flitIdT inId;
  lengthT inLen;
  logic   pktOpen;   // Header seen, tail not yet
  logic   accept;

  assign {inId, inLen} = inFlit;

  // Framing check
  always_comb
  begin
    accept = 1'b0;
    if (inValid && !full)
    begin
      case (inId)
        idHeader:       accept = !pktOpen;
        idBody, idTail: accept = pktOpen;
        default:        accept = 1'b0;   // Unknown id
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      pktOpen <= 1'b0;
      wrEn    <= 1'b0;
      dropped <= 1'b0;
      q.quota <= '0;
    end
    else
    begin
      wrEn    <= accept;
      dropped <= inValid && !accept;
      if (accept && inId == idHeader)
      begin
        pktOpen <= 1'b1;
        q.quota <= inLen;
      end
      else if (accept && inId == idTail)
        pktOpen <= 1'b0;
    end
  end

  always_ff @(posedge clk)
  begin
    if (inValid)
      wrFlit <= inFlit;   // Qualified by wrEn
  end

endmodule

// File: hdl/routerOutput.sv
`timescale 1ns/1ps

module routerOutput (
  input  logic                                       clk,
  input  logic                                       rst,
  input  logic [nocPkg::numPorts-1:0]                inValid,
  input  nocPkg::flitT [nocPkg::numPorts-1:0]        inFlit,
  output logic [nocPkg::numPorts-1:0]                dropped,
  output logic [nocPkg::numPorts-1:0]                full,
  output logic                                       outValid,
  output nocPkg::flitT                               outFlit,
  output nocPkg::portIdxT                            outPort
);
  import nocPkg::*;

  logic [numPorts-1:0] wrEn;
  flitT                wrFlit [numPorts];

  flitQueueIf lane [numPorts] ();

  // Framer and queue per input port
  for (genvar i = 0; i < numPorts; i++)
  begin : gPort
    portInput uIn (
      .clk     (clk),
      .rst     (rst),
      .inValid (inValid[i]),
      .inFlit  (inFlit[i]),
      .full    (full[i]),
      .wrEn    (wrEn[i]),
      .wrFlit  (wrFlit[i]),
      .dropped (dropped[i]),
      .q       (lane[i])
    );

    flitFifo uFifo (
      .clk    (clk),
      .rst    (rst),
      .wrEn   (wrEn[i]),
      .wrFlit (wrFlit[i]),
      .full   (full[i]),
      .q      (lane[i])
    );
  end

  outputArbiter uArb (
    .clk      (clk),
    .rst      (rst),
    .lane     (lane),
    .outValid (outValid),
    .outFlit  (outFlit),
    .outPort  (outPort)
  );

endmodule

// File: run.sh
#!/bin/sh
# Build and run the router output testbench with Verilator

rm -f sim.log

verilator --binary --timing --assert -f verilog.f --top-module routerOutputTb -o simv \
  && ./obj_dir/simv > sim.log 2>&1 \
  ; cat sim.log 2>/dev/null

grep -q "^RESULT: PASS$" sim.log && echo "Simulation passed" && exit 0 \
  || echo "Simulation failed" && exit 1

// File: tb/routerOutputTb.sv
`timescale 1ns/1ps

module routerOutputTb;
  import nocPkg::*;
  import arbPkg::*;

  localparam int dirCycles  = 8;
  localparam int randCycles = 300;
  localparam int loadCycles = 200;
  localparam int cycleLimit = (dirCycles + randCycles + loadCycles) * 4;

  logic                        clk;
  logic                        rst;
  logic [numPorts-1:0]         inValid;
  flitT [numPorts-1:0]         inFlit;
  logic [numPorts-1:0]         dropped;
  logic [numPorts-1:0]         full;
  logic                        outValid;
  flitT                        outFlit;
  portIdxT                     outPort;

  flitT                expQ [numPorts][$];   // Accepted flits per port
  int                  occ [numPorts];       // FIFO entries plus write in flight
  logic                pktOpen [numPorts];
  logic [numPorts-1:0] expDrop;
  int                  errors;
  int                  cycles;
  int                  runLen;
  portIdxT             lastPort;
  logic                hadOut;
  logic                prevOut;
  logic                rotChk;
  integer              seed;

  routerOutput UUT (
    .clk      (clk),
    .rst      (rst),
    .inValid  (inValid),
    .inFlit   (inFlit),
    .dropped  (dropped),
    .full     (full),
    .outValid (outValid),
    .outFlit  (outFlit),
    .outPort  (outPort)
  );

  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk)
  begin
    cycles++;
    if (cycles > cycleLimit)
    begin
      $display("Timeout: run went past %0d cycles, flits still pending", cycleLimit);
      $display("RESULT: FAIL");
      $finish;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~
  // Flit builders
  // ~~~~~~~~~~~~~~~~~~~~
  function automatic flitT makeFlit(int p, flitIdT id);
    if (id == idHeader)
      return {id, lengthT'((p % 4) + 1)};   // Quota 1 to 4, fixed per port
    return {id, lengthT'($random(seed))};
  endfunction

  function automatic flitT legalFlit(int p, logic open);
    if (!open)
      return makeFlit(p, idHeader);
    return makeFlit(p, (($random(seed) & 3) == 0) ? idTail : idBody);
  endfunction

  // ~~~~~~~~~~~~~~~~~~~~
  // Checks on the outputs
  // ~~~~~~~~~~~~~~~~~~~~
  task automatic checkOutputs();
    flitT want;
    assert (dropped == expDrop)
    else
    begin
      $display("MISMATCH t=%0t dropped exp=%b got=%b", $time, expDrop, dropped);
      errors++;
    end
    if (outValid)
    begin
      assert (expQ[outPort].size() > 0)
      else
      begin
        $display("Flit came out of port %0d with no accepted flit queued", outPort);
        errors++;
      end
      if (expQ[outPort].size() > 0)
      begin
        want = expQ[outPort].pop_front();
        occ[outPort]--;
        assert (outFlit == want)
        else
        begin
          $display("MISMATCH t=%0t outFlit exp=%h got=%h", $time, want, outFlit);
          errors++;
        end
      end
      runLen = (prevOut && outPort == lastPort) ? runLen + 1 : 1;
      assert (runLen <= (outPort % 4) + 1)
      else
      begin
        $display("Port %0d sent %0d flits in one turn, over its quota", outPort, runLen);
        errors++;
      end
      // A new turn starts after a gap or on a port change
      if (rotChk && hadOut && (outPort != lastPort || !prevOut))
      begin
        assert (outPort == portIdxT'((lastPort + 1) % numPorts))
        else
        begin
          $display("MISMATCH t=%0t outPort exp=%0d got=%0d", $time,
                   (lastPort + 1) % numPorts, outPort);
          errors++;
        end
      end
      lastPort = outPort;
      hadOut   = 1'b1;
    end
    prevOut = outValid;
    for (int p = 0; p < numPorts; p++)
      assert (full[p] == (occ[p] == fifoDepth))
      else
      begin
        $display("MISMATCH t=%0t full[%0d] exp=%b got=%b", $time, p,
                 occ[p] == fifoDepth, full[p]);
        errors++;
      end
  endtask

  // One cycle: check, model the framer, then drive
  task automatic cycleStep(input logic [numPorts-1:0] vld, input flitT [numPorts-1:0] f);
    flitIdT id;
    logic   ok;
    @(posedge clk);
    #1;
    checkOutputs();
    for (int p = 0; p < numPorts; p++)
    begin
      expDrop[p] = 1'b0;
      if (vld[p])
      begin
        id = f[p][14:12];
        ok = (occ[p] < fifoDepth) &&
             ((id == idHeader && !pktOpen[p]) ||
              ((id == idBody || id == idTail) && pktOpen[p]));
        if (ok)
        begin
          expQ[p].push_back(f[p]);
          occ[p]++;
          if (id == idHeader)
            pktOpen[p] = 1'b1;
          else if (id == idTail)
            pktOpen[p] = 1'b0;
        end
        else
          expDrop[p] = 1'b1;
      end
    end
    inValid = vld;
    inFlit  = f;
  endtask

  initial
  begin
    logic [numPorts-1:0] vld;
    flitT [numPorts-1:0] f;
    logic                busy;
    seed    = 78664;
    errors  = 0;
    cycles  = 0;
    runLen  = 0;
    hadOut  = 1'b0;
    prevOut = 1'b0;
    rotChk  = 1'b0;
    expDrop = '0;
    lastPort = '0;
    rst     = 1'b1;
    inValid = '0;
    inFlit  = '0;
    for (int p = 0; p < numPorts; p++)
    begin
      occ[p]     = 0;
      pktOpen[p] = 1'b0;
    end
    repeat (3) @(posedge clk);
    #1 rst = 1'b0;
    assert (!outValid && dropped == '0 && full == '0)
    else
    begin
      $display("Outputs not idle after reset");
      errors++;
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // Framing errors
    // ~~~~~~~~~~~~~~~~~~~~
    f = '0;
    f[0] = makeFlit(0, idBody);      // No open packet
    f[1] = makeFlit(1, idTail);
    f[2] = makeFlit(2, idHeader);
    cycleStep(5'b00111, f);
    f[2] = makeFlit(2, idHeader);    // Header inside open packet
    f[3] = makeFlit(3, idHeader);
    cycleStep(5'b01100, f);
    f[2] = makeFlit(2, idTail);
    f[3] = makeFlit(3, idTail);
    cycleStep(5'b01100, f);
    repeat (dirCycles - 3) cycleStep('0, f);

    // Random traffic with some broken framing
    repeat (randCycles)
    begin
      for (int p = 0; p < numPorts; p++)
      begin
        vld[p] = 1'($random(seed) & 1);
        if (($random(seed) & 7) == 0)
          f[p] = makeFlit(p, flitIdT'(3'b001 << ($unsigned($random(seed)) % 3)));
        else
          f[p] = legalFlit(p, pktOpen[p]);
      end
      cycleStep(vld, f);
    end

    // All ports loaded, FIFOs fill and overflow
    for (int c = 0; c < loadCycles; c++)
    begin
      rotChk = (c >= 30);
      for (int p = 0; p < numPorts; p++)
        f[p] = legalFlit(p, pktOpen[p]);
      cycleStep('1, f);
    end
    rotChk = 1'b0;

    // Drain
    busy = 1'b1;
    while (busy)
    begin
      cycleStep('0, f);
      busy = 1'b0;
      for (int p = 0; p < numPorts; p++)
        if (occ[p] != 0)
          busy = 1'b1;
    end
    repeat (4) cycleStep('0, f);

    $display("Errors: %0d after %0d cycles", errors, cycles);
    if (errors == 0)
      $display("RESULT: PASS");
    else
      $display("RESULT: FAIL");
    $finish;
  end

endmodule

// File: verilog.f
hdl/nocPkg.sv
hdl/arbPkg.sv
hdl/flitQueueIf.sv
hdl/portInput.sv
hdl/flitFifo.sv
hdl/grantTimer.sv
hdl/outputArbiter.sv
hdl/routerOutput.sv
tb/routerOutputTb.sv
